/* verilog/sensor_defines.svh */
`ifndef SENSOR_DEFINES_SVH
`define SENSOR_DEFINES_SVH

// adc reset hold after reset falls, same count reused for settling
`define SENSOR_RESET_CYCLES	16

// max wait on busy or ready before a read is abandoned
`define SENSOR_DRP_TIMEOUT	10'd1023

// drp register map, status block
`define SENSOR_ADDR_TEMP	7'h00
`define SENSOR_ADDR_VCCINT	7'h01
`define SENSOR_ADDR_VCCAUX	7'h02
`define SENSOR_ADDR_VCCBRAM	7'h06

// first of sixteen external result registers
`define SENSOR_ADDR_EXT0	7'h10

// temp = code * 503.975 / 4096 - 273.15
`define SENSOR_TEMP_GAIN	32'h0001F7F9	// 0x1F7.F9
`define SENSOR_TEMP_OFFSET	32'h00011126	// 0x111.26

// rails full scale is 3V, so volts = code * 3 / 4096
`define SENSOR_VOLT_GAIN	32'd3

`endif

/* verilog/sensor_pkg.sv */
package sensor_pkg;

	// drp command toward the adc, read only
	typedef struct packed {
		logic		en;		// one cycle strobe
		logic [6:0]	addr;
	} drp_req_t;

	typedef struct packed {
		logic			ready;	// one cycle, dout valid
		logic [15:0]	dout;	// code sits in the top 12 bits
		logic			busy;
	} drp_rsp_t;

	// tag carried through the scaling pipeline
	typedef enum logic [2:0] {
		id_temp,
		id_vccint,
		id_vccaux,
		id_vccbram,
		id_ext		// never scaled
	} sensor_id_t;

	typedef struct packed {
		logic			valid;
		sensor_id_t		id;
		logic [11:0]	code;
	} conv_in_t;

	typedef struct packed {
		logic			valid;
		sensor_id_t		id;
		logic [15:0]	value;	// 8.8 fixed point
	} conv_out_t;

	// all 8.8 except the native code
	typedef struct packed {
		logic [15:0]	die_temp;			// deg C
		logic [15:0]	volt_core;
		logic [15:0]	volt_aux;
		logic [15:0]	volt_ram;
		logic [11:0]	die_temp_native;	// raw adc code
	} sensor_readings_t;

endpackage

/* verilog/fixp_scale.sv */
`timescale 1ns/1ps
`include "sensor_defines.svh"

module fixp_scale (
	input  logic					clk,
	input  logic					reset,
	input  sensor_pkg::conv_in_t	conv_in,
	output sensor_pkg::conv_out_t	conv_out
);
	import sensor_pkg::*;

	logic [11:0]	mult_a;		// stage 1 operands
	logic [31:0]	mult_b;
	logic [31:0]	prod;		// stage 2
	logic [31:0]	temp_raw;
	logic [1:0]		vld;		// valid for stages 1 and 2
	sensor_id_t		id1;
	sensor_id_t		id2;
	logic			out_valid;	// stage 3
	sensor_id_t		out_id;
	logic [15:0]	out_value;

	// >>12 for the /4096, result keeps 8 fraction bits
	assign temp_raw = {12'd0, prod[31:12]} - `SENSOR_TEMP_OFFSET;

	always_ff @(posedge clk) begin
		if (reset) begin
			vld			<= '0;
			out_valid	<= 1'b0;
		end else begin
			vld			<= {vld[0], conv_in.valid};
			out_valid	<= vld[1];
		end
	end

	always_ff @(posedge clk) begin
		mult_a	<= conv_in.code;
		mult_b	<= (conv_in.id == id_temp) ? `SENSOR_TEMP_GAIN : `SENSOR_VOLT_GAIN;
		id1		<= conv_in.id;

		prod	<= {20'd0, mult_a} * mult_b;
		id2		<= id1;

		out_id	<= id2;
		// rails are integer gain, >>12 then <<8 leaves a net shift of 4
		out_value <= (id2 == id_temp) ? temp_raw[15:0] : prod[19:4];
	end

	assign conv_out = '{valid: out_valid, id: out_id, value: out_value};

endmodule

/* verilog/drp_port.sv */
`timescale 1ns/1ps
`include "sensor_defines.svh"

module drp_port (
	input  logic					clk,
	input  logic					reset,
	input  logic					rd_req,
	input  logic [6:0]				rd_addr,
	output logic					rd_ack,
	output logic [11:0]				rd_code,
	output logic					rd_fault,
	output sensor_pkg::drp_req_t	drp_req,
	input  sensor_pkg::drp_rsp_t	drp_rsp
);

	typedef enum logic [1:0] {
		st_idle,
		st_busy,	// holding off until the adc is free
		st_wait,	// strobe sent, waiting for ready
		st_ack		// ack up until requester lets go
	} state_t;

	state_t		state;
	logic [9:0]	cnt;		// cycles spent in the current wait
	logic [6:0]	addr_q;
	logic		en_q;		// registered strobe
	logic		timed_out;

	assign timed_out = (cnt == `SENSOR_DRP_TIMEOUT);

	// strobe goes out the cycle after busy is seen low
	assign drp_req = '{en: en_q, addr: addr_q};

	always_ff @(posedge clk) begin
		if (reset) begin
			state		<= st_idle;
			cnt			<= '0;
			en_q		<= 1'b0;
			rd_ack		<= 1'b0;
			rd_fault	<= 1'b0;
		end else begin
			en_q <= 1'b0;	// single cycle strobe
			case (state)
				st_idle: if (rd_req) begin
					addr_q	<= rd_addr;
					cnt		<= '0;
					state	<= st_busy;
				end
				st_busy: begin
					cnt <= cnt + 10'd1;
					if (!drp_rsp.busy) begin
						en_q	<= 1'b1;
						cnt		<= '0;		// restart count for the ready wait
						state	<= st_wait;
					end else if (timed_out) begin
						rd_fault	<= 1'b1;	// busy never cleared
						rd_ack		<= 1'b1;
						state		<= st_ack;
					end
				end
				st_wait: begin
					cnt <= cnt + 10'd1;
					if (drp_rsp.ready) begin
						rd_code		<= drp_rsp.dout[15:4];	// drop the 4 lsbs
						rd_fault	<= 1'b0;
						rd_ack		<= 1'b1;
						state		<= st_ack;
					end else if (timed_out) begin
						rd_fault	<= 1'b1;
						rd_ack		<= 1'b1;
						state		<= st_ack;
					end
				end
				st_ack: if (!rd_req) begin
					rd_ack	<= 1'b0;
					state	<= st_idle;
				end
				default: state <= st_idle;
			endcase
		end
	end

	// exactly one strobe per access
	a_en_pulse: assert property (@(posedge clk) disable iff (reset)
		drp_req.en |=> !drp_req.en);

	// never strobe into a busy adc
	a_en_not_busy: assert property (@(posedge clk) disable iff (reset)
		$rose(drp_req.en) |-> !drp_rsp.busy);

endmodule

/* verilog/ext_capture.sv */
`timescale 1ns/1ps

module ext_capture (
	input  logic			clk,
	input  logic			reset,
	input  logic			ext_valid,
	input  logic [3:0]		ext_index,
	input  logic [11:0]		ext_code,
	input  logic			ext_done,
	output logic [191:0]	ext_in,		// slot n at 12n +: 12
	output logic			ext_update
);

	logic [3:0] last_slot;	// most recent slot written

	always_ff @(posedge clk) begin
		if (reset) begin
			ext_in		<= '0;
			ext_update	<= 1'b0;
			last_slot	<= '0;
		end else begin
			ext_update <= ext_done;		// one cycle behind done
			if (ext_valid) begin
				ext_in[ext_index * 12 +: 12]	<= ext_code;
				last_slot						<= ext_index;
			end
		end
	end

	// done only closes a full sweep ending at channel 15
	a_done_after_last: assert property (@(posedge clk) disable iff (reset)
		ext_done |-> (last_slot == 4'd15) && !ext_valid);

endmodule

/* verilog/poll_ctrl.sv */
`timescale 1ns/1ps
`include "sensor_defines.svh"

module poll_ctrl (
	input  logic							clk,
	input  logic							reset,
	output logic							adc_reset,
	output logic							rd_req,
	output logic [6:0]						rd_addr,
	input  logic							rd_ack,
	input  logic [11:0]						rd_code,
	input  logic							rd_fault,
	output sensor_pkg::conv_in_t			conv_in,
	input  sensor_pkg::conv_out_t			conv_out,
	output sensor_pkg::sensor_readings_t	readings,
	output logic							sensors_update,
	output logic							ext_valid,
	output logic [3:0]						ext_index,
	output logic [11:0]						ext_code,
	output logic							ext_done,
	output logic							drp_fault
);
	import sensor_pkg::*;

	typedef enum logic [2:0] {
		st_reset,	// adc held in reset
		st_settle,	// released, let it start sampling
		st_read,	// rd_req up until ack
		st_release,	// rd_req down, wait for ack to clear
		st_drain	// last rail still in the multiplier
	} state_t;

	state_t				state;
	logic [7:0]			cnt;		// reset and settle timer
	logic [4:0]			step;		// 0 temp, 1..3 rails, 4..19 ext channels
	logic [3:0]			ext_off;	// external channel of the current step
	logic				flt;		// last read was abandoned
	sensor_id_t			step_id;
	sensor_readings_t	pend;		// this round, not yet published
	sensor_readings_t	pend_next;

	assign ext_off = 4'(step - 5'd4);

	// register address and scaling tag for the current step
	always_comb begin
		step_id = id_ext;
		rd_addr = `SENSOR_ADDR_EXT0 + {3'd0, ext_off};
		case (step)
			5'd0: begin
				step_id = id_temp;
				rd_addr = `SENSOR_ADDR_TEMP;
			end
			5'd1: begin
				step_id = id_vccint;
				rd_addr = `SENSOR_ADDR_VCCINT;
			end
			5'd2: begin
				step_id = id_vccaux;
				rd_addr = `SENSOR_ADDR_VCCAUX;
			end
			5'd3: begin
				step_id = id_vccbram;
				rd_addr = `SENSOR_ADDR_VCCBRAM;
			end
			default: ;
		endcase
	end

	// sort pipeline results by tag
	always_comb begin
		pend_next = pend;
		if (conv_out.valid) begin
			case (conv_out.id)
				id_temp:	pend_next.die_temp = conv_out.value;
				id_vccint:	pend_next.volt_core = conv_out.value;
				id_vccaux:	pend_next.volt_aux = conv_out.value;
				id_vccbram:	pend_next.volt_ram = conv_out.value;
				default: ;
			endcase
		end
		if (state == st_read && rd_ack && !rd_fault && step == 5'd0)
			pend_next.die_temp_native = rd_code;	// raw code kept as is
	end

	always_ff @(posedge clk)
		pend <= pend_next;

	always_ff @(posedge clk) begin
		conv_in.valid	<= 1'b0;
		ext_valid		<= 1'b0;
		ext_done		<= 1'b0;
		sensors_update	<= 1'b0;
		drp_fault		<= 1'b0;
		if (reset) begin
			state		<= st_reset;
			cnt			<= '0;
			step		<= '0;
			flt			<= 1'b0;
			adc_reset	<= 1'b1;
			rd_req		<= 1'b0;
			conv_in		<= '0;
			readings	<= '0;
		end else begin
			case (state)
				st_reset: begin
					cnt <= cnt + 8'd1;
					if (cnt == 8'(`SENSOR_RESET_CYCLES - 1)) begin
						adc_reset	<= 1'b0;
						cnt			<= '0;
						state		<= st_settle;
					end
				end
				st_settle: begin
					cnt <= cnt + 8'd1;
					if (cnt == 8'(`SENSOR_RESET_CYCLES - 1)) begin
						rd_req	<= 1'b1;	// first read, temperature
						state	<= st_read;
					end
				end
				st_read: if (rd_ack) begin
					rd_req	<= 1'b0;
					flt		<= rd_fault;
					state	<= st_release;
					if (rd_fault) begin
						drp_fault <= 1'b1;
					end else if (step < 5'd4) begin
						conv_in.valid	<= 1'b1;	// status regs go through scaling
						conv_in.id		<= step_id;
						conv_in.code	<= rd_code;
					end else begin
						ext_valid	<= 1'b1;
						ext_index	<= ext_off;
						ext_code	<= rd_code;
					end
				end
				st_release: if (!rd_ack) begin
					if (flt) begin
						step	<= '0;		// abandon round, start over at temp
						rd_req	<= 1'b1;
						state	<= st_read;
					end else if (step == 5'd3) begin
						state	<= st_drain;
					end else if (step == 5'd19) begin
						ext_done	<= 1'b1;	// last external channel
						step		<= '0;
						rd_req		<= 1'b1;
						state		<= st_read;
					end else begin
						step	<= step + 5'd1;
						rd_req	<= 1'b1;
						state	<= st_read;
					end
				end
				st_drain: if (conv_out.valid && conv_out.id == id_vccbram) begin
					readings		<= pend_next;	// publish all four at once
					sensors_update	<= 1'b1;
					step			<= 5'd4;
					rd_req			<= 1'b1;
					state			<= st_read;
				end
				default: state <= st_reset;
			endcase
		end
	end

	// port must have dropped the previous ack first
	a_req_after_ack: assert property (@(posedge clk) disable iff (reset)
		$rose(rd_req) |-> !rd_ack);

	// each result belongs to a tag sent three cycles before
	a_tag_issued: assert property (@(posedge clk) disable iff (reset)
		conv_out.valid |-> $past(conv_in.valid, 3) && ($past(conv_in.id, 3) == conv_out.id));

endmodule

/* verilog/sensor_mon.sv */
`timescale 1ns/1ps

module sensor_mon (
	input  logic							clk,
	input  logic							reset,
	output sensor_pkg::drp_req_t			drp_req,
	input  sensor_pkg::drp_rsp_t			drp_rsp,
	output logic							adc_reset,
	output sensor_pkg::sensor_readings_t	readings,
	output logic							sensors_update,
	output logic [191:0]					ext_in,		// channel n at 12n +: 12
	output logic							ext_update,
	output logic							drp_fault
);
	import sensor_pkg::*;

	// sequencer to register port, four phase
	logic			rd_req;
	logic [6:0]		rd_addr;
	logic			rd_ack;
	logic [11:0]	rd_code;
	logic			rd_fault;

	// scaling pipeline, 3 cycle fixed latency
	conv_in_t		conv_in;
	conv_out_t		conv_out;

	// external channel writes, unscaled
	logic			ext_valid;
	logic [3:0]		ext_index;
	logic [11:0]	ext_code;
	logic			ext_done;

	poll_ctrl ctrl0 (
		.clk			(clk),
		.reset			(reset),
		.adc_reset		(adc_reset),
		.rd_req			(rd_req),
		.rd_addr		(rd_addr),
		.rd_ack			(rd_ack),
		.rd_code		(rd_code),
		.rd_fault		(rd_fault),
		.conv_in		(conv_in),
		.conv_out		(conv_out),
		.readings		(readings),
		.sensors_update	(sensors_update),
		.ext_valid		(ext_valid),
		.ext_index		(ext_index),
		.ext_code		(ext_code),
		.ext_done		(ext_done),
		.drp_fault		(drp_fault)
	);

	drp_port port0 (
		.clk		(clk),
		.reset		(reset),
		.rd_req		(rd_req),
		.rd_addr	(rd_addr),
		.rd_ack		(rd_ack),
		.rd_code	(rd_code),
		.rd_fault	(rd_fault),
		.drp_req	(drp_req),
		.drp_rsp	(drp_rsp)
	);

	fixp_scale scale0 (.clk(clk), .reset(reset), .conv_in(conv_in), .conv_out(conv_out));

	ext_capture cap0 (
		.clk		(clk),
		.reset		(reset),
		.ext_valid	(ext_valid),
		.ext_index	(ext_index),
		.ext_code	(ext_code),
		.ext_done	(ext_done),
		.ext_in		(ext_in),
		.ext_update	(ext_update)
	);

endmodule

/* dv/adc_model.sv */
`timescale 1ns/1ps

module adc_model (
	input  logic					clk,
	input  logic					adc_reset,
	input  sensor_pkg::drp_req_t	drp_req,
	output sensor_pkg::drp_rsp_t	drp_rsp
);
	import sensor_pkg::*;

	logic [15:0]	regs [0:127];		// register file, code in the top 12 bits
	int				ready_delay = 0;	// extra cycles from strobe to ready
	int				busy_stretch = 0;	// busy cycles after each ready
	logic			stuck = 1'b0;		// swallow strobes, ready never comes
	logic			strobe = 1'b0;		// en seen at the last rising edge
	logic [6:0]		strobe_addr = '0;
	logic			pending = 1'b0;		// read accepted, ready not yet given
	logic [6:0]		pend_addr = '0;
	int				delay_cnt = 0;
	int				busy_cnt = 0;
	drp_rsp_t		rsp = '0;

	assign drp_rsp = rsp;

	// fill depends on every address bit
	initial begin
		for (int i = 0; i < 128; i++)
			regs[i] = 16'(i * 16'h0131) ^ 16'ha5c0;
	end

	task automatic set_reg(input logic [6:0] addr, input logic [15:0] value);
		regs[addr] = value;
	endtask

	task automatic set_timing(input int delay, input int stretch);
		ready_delay = delay;
		busy_stretch = stretch;
	endtask

	task automatic set_stuck(input logic on);
		stuck = on;
	endtask

	// the adc takes the strobe on the rising edge
	always @(posedge clk) begin
		strobe		<= drp_req.en;
		strobe_addr	<= drp_req.addr;
	end

	// responses change on the falling edge only
	always @(negedge clk) begin
		rsp.ready = 1'b0;	// ready is a single cycle pulse
		if (adc_reset) begin
			pending = 1'b0;
			busy_cnt = 0;
		end else begin
			if (busy_cnt != 0)
				busy_cnt--;
			if (pending) begin
				if (delay_cnt == 0) begin
					rsp.ready = 1'b1;
					rsp.dout = regs[pend_addr];
					pending = 1'b0;
					busy_cnt = busy_stretch;	// busy tail after the result
				end else begin
					delay_cnt--;
				end
			end
			if (strobe && !stuck) begin
				pending = 1'b1;
				pend_addr = strobe_addr;
				delay_cnt = ready_delay;
			end
		end
		rsp.busy = (busy_cnt != 0);
	end

endmodule

/* dv/sensor_mon_tb.sv */
`timescale 1ns/1ps
`include "sensor_defines.svh"

module sensor_mon_tb;
	import sensor_pkg::*;

	localparam int slow_delay = 40;		// back-pressure ready delay
	localparam int slow_stretch = 25;	// back-pressure busy tail
	localparam int fast_round = 20 * 12 + 8;	// about 12 cycles per read unstretched
	localparam int slow_round = 20 * (12 + slow_delay + slow_stretch);
	// reset and settle, ~16 fast rounds, 3 slow rounds, one abandoned read, all doubled
	localparam int cycle_limit = 2 * (4 * `SENSOR_RESET_CYCLES + 16 * fast_round
		+ 3 * slow_round + 2 * `SENSOR_DRP_TIMEOUT);

	logic				clk;
	logic				reset;
	drp_req_t			drp_req;
	drp_rsp_t			drp_rsp;
	logic				adc_reset;
	sensor_readings_t	readings;
	logic				sensors_update;
	logic [191:0]		ext_in;
	logic				ext_update;
	logic				drp_fault;
	int					cycles = 0;
	int					mismatches = 0;
	int					problems = 0;
	int					fault_count = 0;	// drp_fault pulses over the whole run

	sensor_mon dut0 (
		.clk			(clk),
		.reset			(reset),
		.drp_req		(drp_req),
		.drp_rsp		(drp_rsp),
		.adc_reset		(adc_reset),
		.readings		(readings),
		.sensors_update	(sensors_update),
		.ext_in			(ext_in),
		.ext_update		(ext_update),
		.drp_fault		(drp_fault)
	);

	adc_model adc0 (.clk(clk), .adc_reset(adc_reset), .drp_req(drp_req), .drp_rsp(drp_rsp));

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= cycle_limit) begin
			$display("timeout: run went past %0d cycles without finishing", cycle_limit);
			$display("SIMULATION FAILED");
			$finish;
		end
	end

	always @(negedge clk)
		if (drp_fault === 1'b1)
			fault_count++;

	// 8.8 degrees C, product of code and gain scaled down by 4096, offset removed
	function automatic logic [15:0] temp_expect(input logic [11:0] code);
		logic [31:0] product;
		product = 32'(code) * `SENSOR_TEMP_GAIN;
		return 16'((product >> 12) - `SENSOR_TEMP_OFFSET);
	endfunction

	// 8.8 volts, code * 3 / 4096 with 8 fraction bits
	function automatic logic [15:0] rail_expect(input logic [11:0] code);
		logic [31:0] scaled;
		scaled = 32'(code) * `SENSOR_VOLT_GAIN * 32'd256;
		return 16'(scaled / 32'd4096);
	endfunction

	task automatic flag_mismatch(input string msg);
		mismatches++;
		$display("FAILED at %0t ns: %s", $time, msg);
	endtask

	task automatic flag_problem(input string msg);
		problems++;
		$display("at %0t ns: %s", $time, msg);
	endtask

	// pulses are checked at the falling edge, mid cycle
	task automatic wait_sensors_update;
		@(negedge clk);
		while (sensors_update !== 1'b1)
			@(negedge clk);
	endtask

	task automatic wait_ext_update;
		@(negedge clk);
		while (ext_update !== 1'b1)
			@(negedge clk);
	endtask

	task automatic check_reset;
		int high_cycles;
		int settle_cycles;
		repeat (5) begin
			@(negedge clk);
			if (sensors_update !== 1'b0 || ext_update !== 1'b0 || drp_req.en !== 1'b0
				|| drp_fault !== 1'b0)
				flag_problem("an update, strobe or fault output was active during reset");
			if (adc_reset !== 1'b1)
				flag_problem("adc_reset was not held high during reset");
			if (readings !== '0)
				flag_mismatch($sformatf("readings %h during reset, expected zero", readings));
			if (ext_in !== '0)
				flag_mismatch($sformatf("ext_in %h during reset, expected zero", ext_in));
		end
		reset = 1'b0;
		high_cycles = 0;
		while (adc_reset === 1'b1) begin
			high_cycles++;
			if (drp_req.en !== 1'b0)
				flag_problem("drp strobe while the adc was held in reset");
			@(negedge clk);
		end
		if (high_cycles != `SENSOR_RESET_CYCLES)
			flag_mismatch($sformatf("adc_reset high %0d cycles, expected %0d", high_cycles,
				`SENSOR_RESET_CYCLES));
		settle_cycles = 0;
		while (drp_req.en !== 1'b1) begin	// first strobe ends the settle wait
			settle_cycles++;
			@(negedge clk);
		end
		if (settle_cycles < `SENSOR_RESET_CYCLES)
			flag_problem("first drp strobe came before the settle time had passed");
	endtask

	task automatic check_temperature;
		logic [11:0] code;
		logic [3:0] lsbs;
		for (int n = 0; n < 4; n++) begin
			code = 12'($urandom);
			lsbs = 4'($urandom);	// below the code, must be dropped
			adc0.set_reg(`SENSOR_ADDR_TEMP, {code, lsbs});
			wait_sensors_update;	// first update may predate the write
			wait_sensors_update;
			if (readings.die_temp !== temp_expect(code))
				flag_mismatch($sformatf("die_temp %h for code %h, expected %h",
					readings.die_temp, code, temp_expect(code)));
			if (readings.die_temp_native !== code)
				flag_mismatch($sformatf("die_temp_native %h, expected %h",
					readings.die_temp_native, code));
		end
	endtask

	task automatic check_rails;
		logic [11:0] c_core;
		logic [11:0] c_aux;
		logic [11:0] c_ram;
		c_core = 12'($urandom);
		c_aux = 12'($urandom);
		c_ram = 12'($urandom);
		if (c_aux == c_core)
			c_aux = ~c_core;	// keep the three apart so routing shows
		if (c_ram == c_core || c_ram == c_aux)
			c_ram = c_core ^ c_aux ^ 12'h5a5;
		adc0.set_reg(`SENSOR_ADDR_VCCINT, {c_core, 4'h3});
		adc0.set_reg(`SENSOR_ADDR_VCCAUX, {c_aux, 4'hc});
		adc0.set_reg(`SENSOR_ADDR_VCCBRAM, {c_ram, 4'h9});
		wait_sensors_update;
		wait_sensors_update;
		if (readings.volt_core !== rail_expect(c_core))
			flag_mismatch($sformatf("volt_core %h, expected %h", readings.volt_core,
				rail_expect(c_core)));
		if (readings.volt_aux !== rail_expect(c_aux))
			flag_mismatch($sformatf("volt_aux %h, expected %h", readings.volt_aux,
				rail_expect(c_aux)));
		if (readings.volt_ram !== rail_expect(c_ram))
			flag_mismatch($sformatf("volt_ram %h, expected %h", readings.volt_ram,
				rail_expect(c_ram)));
	endtask

	task automatic check_external;
		logic [11:0] codes [16];
		for (int i = 0; i < 16; i++) begin
			codes[i] = 12'($urandom);
			adc0.set_reg(`SENSOR_ADDR_EXT0 + 7'(i), {codes[i], 4'(i)});
		end
		wait_ext_update;
		wait_ext_update;	// one full sweep after all writes
		for (int i = 0; i < 16; i++)
			if (ext_in[12 * i +: 12] !== codes[i])
				flag_mismatch($sformatf("ext channel %0d is %h, expected %h", i,
					ext_in[12 * i +: 12], codes[i]));
	endtask

	task automatic check_back_pressure;
		sensor_readings_t saved_readings;
		logic [191:0] saved_ext;
		int faults_before;
		saved_readings = readings;	// unstretched results, registers untouched since
		saved_ext = ext_in;
		faults_before = fault_count;
		adc0.set_timing(slow_delay, slow_stretch);
		wait_ext_update;	// end of the partly fast round
		wait_sensors_update;
		if (readings !== saved_readings)
			flag_mismatch($sformatf("stretched readings %h, expected %h", readings,
				saved_readings));
		wait_ext_update;
		if (ext_in !== saved_ext)
			flag_mismatch($sformatf("stretched ext_in %h, expected %h", ext_in, saved_ext));
		adc0.set_timing(0, 0);
		if (fault_count != faults_before)
			flag_problem("drp_fault pulsed during the stretched rounds");
	endtask

	task automatic check_timeout_recovery;
		sensor_readings_t saved_readings;
		logic [11:0] new_code;
		logic saw_update;
		int faults_before;
		wait_ext_update;	// temperature read is next
		saved_readings = readings;
		faults_before = fault_count;
		new_code = 12'($urandom);
		if (new_code == saved_readings.die_temp_native)
			new_code = ~new_code;	// must differ from the published code
		adc0.set_reg(`SENSOR_ADDR_TEMP, {new_code, 4'h0});
		saw_update = 1'b0;
		// temp and core rail go through with the new code, aux read gets stuck
		@(negedge clk);
		while (drp_req.en !== 1'b1 || drp_req.addr !== `SENSOR_ADDR_VCCAUX) begin
			if (sensors_update === 1'b1)
				saw_update = 1'b1;
			@(negedge clk);
		end
		adc0.set_stuck(1'b1);	// this strobe is swallowed
		while (drp_fault !== 1'b1) begin
			if (sensors_update === 1'b1)
				saw_update = 1'b1;
			@(negedge clk);
		end
		adc0.set_stuck(1'b0);	// retried round reads normally
		if (saw_update)
			flag_problem("sensors_update pulsed in the round with the stuck read");
		if (readings !== saved_readings)
			flag_mismatch($sformatf("readings %h after fault, expected %h", readings,
				saved_readings));
		@(negedge clk);
		if (drp_fault !== 1'b0)
			flag_problem("drp_fault stayed high for more than one cycle");
		wait_sensors_update;
		if (readings.die_temp !== temp_expect(new_code))
			flag_mismatch($sformatf("die_temp %h after recovery, expected %h",
				readings.die_temp, temp_expect(new_code)));
		if (readings.die_temp_native !== new_code)
			flag_mismatch($sformatf("die_temp_native %h after recovery, expected %h",
				readings.die_temp_native, new_code));
		if (readings.volt_core !== saved_readings.volt_core)
			flag_mismatch($sformatf("volt_core %h after recovery, expected %h",
				readings.volt_core, saved_readings.volt_core));
		if (fault_count != faults_before + 1)
			flag_problem("the stuck read did not give exactly one drp_fault pulse");
	endtask

	initial begin
		reset = 1'b1;
		void'($urandom(32'hab94_1bee));
		check_reset;
		check_temperature;
		check_rails;
		check_external;
		check_back_pressure;
		check_timeout_recovery;
		if (fault_count != 1)
			flag_problem("drp_fault count over the run differs from the one stuck read");
		$display("value mismatches: %0d, other failures: %0d, drp faults seen: %0d",
			mismatches, problems, fault_count);
		if (mismatches == 0 && problems == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

endmodule

/* sensor_mon.f */
+incdir+verilog
verilog/sensor_pkg.sv
verilog/fixp_scale.sv
verilog/drp_port.sv
verilog/ext_capture.sv
verilog/poll_ctrl.sv
verilog/sensor_mon.sv
dv/adc_model.sv
dv/sensor_mon_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       := sensor_mon_tb
RTL_TOP   := sensor_mon
FILELIST  := sensor_mon.f
OBJ_DIR   := obj_dir
LOG       := sim.log
VFLAGS    := --binary --timing --assert -j 0 -Mdir $(OBJ_DIR)
LINTFLAGS := --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "SIMULATION PASSED" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
